//--- Bender.yml
package:
  name: noc_router

sources:
  - noc_pkg.sv
  - vc_fifo.sv
  - input_port.sv
  - ovc_status.sv
  - vc_sw_alloc.sv
  - crossbar.sv
  - router.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - router_tb.sv

//--- crossbar.sv
module crossbar import noc_pkg::*; (
	input port_mask_t grant_rows [num_ports],
	input flit_t flit_in [num_ports],
	input logic flit_in_valid [num_ports],
	output flit_t flit_out [num_ports],
	output logic flit_out_we [num_ports]
);

	// one-hot and-or mux per output
	always_comb begin
		for (int o = 0; o < num_ports; o++) begin
			flit_out[o] = '0;
			flit_out_we[o] = 1'b0;
			for (int i = 0; i < num_ports; i++) begin
				if (grant_rows[o][i]) begin
					flit_out[o] = flit_out[o] | flit_in[i];
					flit_out_we[o] = flit_out_we[o] | flit_in_valid[i];
				end
			end
		end
	end

endmodule

//--- flist.f
noc_pkg.sv
vc_fifo.sv
input_port.sv
ovc_status.sv
vc_sw_alloc.sv
crossbar.sv
router.sv
tb_clk_gen.sv
router_tb.sv

//--- input_port.sv
module input_port import noc_pkg::*; #(
	parameter int b = 4,
	parameter int nx = 4,
	parameter int ny = 4
) (
	input logic clk,
	input logic reset,
	input coord_t current_x,
	input coord_t current_y,
	input flit_t flit_in,
	input logic flit_in_we,
	output vc_mask_t credit_out,
	output vc_mask_t req,
	output port_mask_t dest_port [num_vc],
	output vc_mask_t has_ovc,
	output vc_mask_t held_ovc [num_vc],
	input vc_mask_t ovc_grant [num_vc],
	input vc_mask_t sw_grant,
	output flit_t flit_out,
	output logic flit_out_valid
);

	flit_t fifo_dout [num_vc];
	vc_mask_t fifo_empty;
	vc_mask_t fifo_wr;
	port_mask_t route_head [num_vc];
	port_mask_t route_q [num_vc];
	flit_t sel_flit;
	vc_mask_t sel_ovc;

	// x first then y then eject
	function automatic port_mask_t xy_route(input coord_t dx, input coord_t dy,
			input coord_t cx, input coord_t cy);
		port_mask_t r;
		r = '0;
		if (dx > cx)
			r[port_east] = 1'b1;
		else if (dx < cx)
			r[port_west] = 1'b1;
		else if (dy < cy)
			r[port_north] = 1'b1;
		else if (dy > cy)
			r[port_south] = 1'b1;
		else
			r[port_local] = 1'b1;
		return r;
	endfunction

	assign fifo_wr = flit_in_we ? flit_in.vc_mask : '0; // demux on input channel

	for (genvar v = 0; v < num_vc; v++) begin : g_vc
		vc_fifo #(
			.depth(b)
		) fifo_i (
			.clk(clk),
			.reset(reset),
			.wr(fifo_wr[v]),
			.din(flit_in),
			.rd(sw_grant[v]),
			.dout(fifo_dout[v]),
			.empty(fifo_empty[v]),
			.full()
		);

		// a head at the front must name a node inside the mesh
		assert property (@(posedge clk) disable iff (reset)
			(!fifo_empty[v] && fifo_dout[v].head) |->
				(int'(fifo_dout[v].payload[coord_w-1:0]) < nx &&
				 int'(fifo_dout[v].payload[2*coord_w-1:coord_w]) < ny));
	end

	always_comb begin
		for (int v = 0; v < num_vc; v++) begin
			route_head[v] = xy_route(fifo_dout[v].payload[coord_w-1:0],
				fifo_dout[v].payload[2*coord_w-1:coord_w], current_x, current_y);
			// body flits follow the route latched from their head
			dest_port[v] = (!fifo_empty[v] && fifo_dout[v].head) ? route_head[v] : route_q[v];
		end
	end

	assign req = ~fifo_empty;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			has_ovc <= '0;
			for (int v = 0; v < num_vc; v++) begin
				held_ovc[v] <= '0;
				route_q[v] <= '0;
			end
		end else begin
			for (int v = 0; v < num_vc; v++) begin
				if (sw_grant[v] && fifo_dout[v].head)
					route_q[v] <= route_head[v];
				if (|ovc_grant[v]) begin
					has_ovc[v] <= 1'b1;
					held_ovc[v] <= ovc_grant[v];
				end else if (sw_grant[v] && fifo_dout[v].tail) begin
					has_ovc[v] <= 1'b0; // release after the tail
					held_ovc[v] <= '0;
				end
			end
		end
	end

	always_comb begin
		sel_flit = '0;
		sel_ovc = '0;
		for (int v = 0; v < num_vc; v++) begin
			if (sw_grant[v]) begin
				sel_flit = fifo_dout[v];
				sel_ovc = held_ovc[v];
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			flit_out_valid <= 1'b0;
			credit_out <= '0;
		end else begin
			flit_out_valid <= |sw_grant;
			credit_out <= sw_grant; // one pulse per popped flit
		end
	end

	always_ff @(posedge clk) begin
		if (|sw_grant) begin
			flit_out <= sel_flit;
			flit_out.vc_mask <= sel_ovc; // travels on the output channel now
		end
	end

endmodule

//--- noc_pkg.sv
package noc_pkg;

	localparam int num_ports = 5; // local plus four mesh neighbours
	localparam int num_vc = 2; // virtual channels per port
	localparam int payload_w = 32;
	localparam int coord_w = 3; // up to an 8 by 8 mesh

	// one mesh coordinate
	typedef logic [coord_w-1:0] coord_t;

	// one-hot virtual channel select
	typedef logic [num_vc-1:0] vc_mask_t;

	// one-hot port select
	typedef logic [num_ports-1:0] port_mask_t;

	// head flit carries dest x in the low bits and dest y right above
	typedef logic [payload_w-1:0] payload_t;

	typedef struct packed {
		logic head; // first flit of a packet
		logic tail; // last flit of a packet
		vc_mask_t vc_mask; // channel the flit travels on
		payload_t payload;
	} flit_t;

	// north is y - 1, south is y + 1
	typedef enum logic [2:0] {
		port_local = 3'd0,
		port_east = 3'd1,
		port_north = 3'd2,
		port_west = 3'd3,
		port_south = 3'd4
	} port_e;

endpackage

//--- ovc_status.sv
module ovc_status import noc_pkg::*; #(
	parameter int b = 4
) (
	input logic clk,
	input logic reset,
	input vc_mask_t credit_in [num_ports],
	input vc_mask_t ovc_alloc [num_ports],
	input vc_mask_t flit_sent [num_ports],
	input vc_mask_t tail_sent [num_ports],
	output vc_mask_t ovc_free [num_ports],
	output vc_mask_t ovc_credit [num_ports]
);

	localparam int cnt_w = $clog2(b + 1);

	typedef logic [cnt_w-1:0] cnt_t;

	cnt_t credit_cnt [num_ports][num_vc]; // free slots downstream
	vc_mask_t allocated [num_ports];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int p = 0; p < num_ports; p++) begin
				allocated[p] <= '0;
				for (int v = 0; v < num_vc; v++)
					credit_cnt[p][v] <= cnt_t'(b);
			end
		end else begin
			for (int p = 0; p < num_ports; p++) begin
				allocated[p] <= (allocated[p] | ovc_alloc[p]) & ~tail_sent[p];
				for (int v = 0; v < num_vc; v++) begin
					case ({flit_sent[p][v], credit_in[p][v]})
						2'b10: credit_cnt[p][v] <= credit_cnt[p][v] - 1'b1;
						2'b01: credit_cnt[p][v] <= credit_cnt[p][v] + 1'b1;
						default: ; // both or neither cancel out
					endcase
				end
			end
		end
	end

	always_comb begin
		for (int p = 0; p < num_ports; p++) begin
			ovc_free[p] = ~allocated[p];
			for (int v = 0; v < num_vc; v++)
				ovc_credit[p][v] = (credit_cnt[p][v] != '0);
		end
	end

	for (genvar p = 0; p < num_ports; p++) begin : g_chk_port
		for (genvar v = 0; v < num_vc; v++) begin : g_chk_vc
			// downstream never returns more credits than it has slots
			assert property (@(posedge clk) disable iff (reset)
				credit_cnt[p][v] <= cnt_t'(b));
			assert property (@(posedge clk) disable iff (reset)
				!(credit_cnt[p][v] == '0 && flit_sent[p][v] && !credit_in[p][v]));
		end
	end

endmodule

//--- router.sv
module router import noc_pkg::*; #(
	parameter int b = 4,
	parameter int nx = 4,
	parameter int ny = 4
) (
	input logic clk,
	input logic reset,
	input coord_t current_x,
	input coord_t current_y,
	input flit_t flit_in [num_ports],
	input logic flit_in_we [num_ports],
	output vc_mask_t credit_out [num_ports],
	output flit_t flit_out [num_ports],
	output logic flit_out_we [num_ports],
	input vc_mask_t credit_in [num_ports]
);

	vc_mask_t req [num_ports];
	port_mask_t dest_port [num_ports][num_vc];
	vc_mask_t has_ovc [num_ports];
	vc_mask_t held_ovc [num_ports][num_vc];
	vc_mask_t ovc_grant [num_ports][num_vc];
	vc_mask_t sw_grant [num_ports];
	flit_t port_flit [num_ports]; // registered input port outputs
	logic port_flit_valid [num_ports];
	vc_mask_t ovc_free [num_ports];
	vc_mask_t ovc_credit [num_ports];
	vc_mask_t ovc_alloc [num_ports];
	vc_mask_t flit_sent [num_ports];
	vc_mask_t tail_sent [num_ports];
	port_mask_t grant_rows [num_ports];
	port_mask_t grant_rows_q [num_ports];

	for (genvar p = 0; p < num_ports; p++) begin : g_port
		input_port #(
			.b(b),
			.nx(nx),
			.ny(ny)
		) input_port_i (
			.clk(clk),
			.reset(reset),
			.current_x(current_x),
			.current_y(current_y),
			.flit_in(flit_in[p]),
			.flit_in_we(flit_in_we[p]),
			.credit_out(credit_out[p]),
			.req(req[p]),
			.dest_port(dest_port[p]),
			.has_ovc(has_ovc[p]),
			.held_ovc(held_ovc[p]),
			.ovc_grant(ovc_grant[p]),
			.sw_grant(sw_grant[p]),
			.flit_out(port_flit[p]),
			.flit_out_valid(port_flit_valid[p])
		);
	end

	vc_sw_alloc alloc_i (
		.clk(clk),
		.reset(reset),
		.req(req),
		.dest_port(dest_port),
		.has_ovc(has_ovc),
		.held_ovc(held_ovc),
		.ovc_free(ovc_free),
		.ovc_credit(ovc_credit),
		.ovc_grant(ovc_grant),
		.sw_grant(sw_grant),
		.grant_rows(grant_rows),
		.ovc_alloc(ovc_alloc),
		.flit_sent(flit_sent),
		.tail_sent(tail_sent)
	);

	ovc_status #(
		.b(b)
	) status_i (
		.clk(clk),
		.reset(reset),
		.credit_in(credit_in),
		.ovc_alloc(ovc_alloc),
		.flit_sent(flit_sent),
		.tail_sent(tail_sent),
		.ovc_free(ovc_free),
		.ovc_credit(ovc_credit)
	);

	// grants line up with the flits popped at the same edge
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int o = 0; o < num_ports; o++)
				grant_rows_q[o] <= '0;
		end else begin
			for (int o = 0; o < num_ports; o++)
				grant_rows_q[o] <= grant_rows[o];
		end
	end

	crossbar xbar_i (
		.grant_rows(grant_rows_q),
		.flit_in(port_flit),
		.flit_in_valid(port_flit_valid),
		.flit_out(flit_out),
		.flit_out_we(flit_out_we)
	);

	// routers on the mesh edge never send off the mesh
	assert property (@(posedge clk) disable iff (reset)
		!((current_x == '0 && flit_out_we[port_west]) ||
		  (current_x == coord_t'(nx - 1) && flit_out_we[port_east]) ||
		  (current_y == '0 && flit_out_we[port_north]) ||
		  (current_y == coord_t'(ny - 1) && flit_out_we[port_south])));

endmodule

//--- router_stim.txt
# columns: test name, input port, input channel, packet length, dest x, dest y,
#          payload seed (hex), expected output port
# ports: 0 local, 1 east, 2 north, 3 west, 4 south; the router sits at x 2, y 1
# lone single-flit packets, one per direction
to_local 1 0 1 2 1 1a2b 0
to_east 3 1 1 3 1 2c3d 1
to_north 0 0 1 2 0 3e4f 2
to_west 1 1 1 0 3 4a5b 3
to_south 2 0 1 2 3 5c6d 4
# multi-flit packets
long_east 0 1 5 3 2 6e7f 1
long_south 2 1 3 2 2 7a8b 4
long_local 4 0 4 2 1 8c9d 0
long_north 3 0 2 2 0 9eaf 2
# two inputs into one output
merge_west 0 0 4 1 1 a1b2 3
merge_west 4 1 3 0 0 b3c4 3
# three packets for the two local channels
merge_local 1 0 3 2 1 c5d6 0
merge_local 3 0 2 2 1 d7e8 0
merge_local 4 1 4 2 1 e9fa 0
# east credits withheld until eight flits are out
east_hold 0 0 6 3 1 f1e2 1
east_hold 2 1 6 3 3 0d1c 1
# a lone packet once the credits are back
east_again 3 0 1 3 0 2b3a 1

//--- router_tb.sv
module router_tb import noc_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int b = 4;
	localparam int nx = 4;
	localparam int ny = 4;
	localparam coord_t my_x = 2;
	localparam coord_t my_y = 1;

	typedef struct packed {
		flit_t f;
		logic [15:0] pkt; // stim line of the packet
		logic [31:0] wr_cycle; // negedge count when the DUT took it
	} exp_t;

	logic clk;
	logic reset;
	flit_t flit_in [num_ports];
	logic flit_in_we [num_ports];
	vc_mask_t credit_out [num_ports];
	flit_t flit_out [num_ports];
	logic flit_out_we [num_ports];
	vc_mask_t credit_in [num_ports];

	string names [$];
	int in_port [$];
	int in_vc [$];
	int pkt_len [$];
	int exp_port [$];
	int first_flit [$];
	logic lone [$]; // single-flit packet alone in its test
	flit_t stim_flits [$];

	exp_t exp_q [num_ports][$]; // scoreboard per output port
	int up_credit [num_ports][num_vc]; // credits held toward each input channel
	int owed [num_ports][num_vc]; // credits still to return per output channel
	int credit_cnt [num_ports][num_vc];
	int sent_cnt [num_ports][num_vc];
	int cur_pkt [num_ports][num_vc];
	int cur_src [num_ports][num_vc];
	logic open_pkt [num_ports][num_vc];
	integer seed;
	int cycle;
	int limit;
	logic hold_east;
	logic first_write;
	int east_held;
	int err_flit;
	int err_port;
	int err_credit;
	int err_lat;
	int err_other;

	tb_clk_gen clk_gen_i (
		.clk(clk),
		.reset(reset)
	);

	router #(
		.b(b),
		.nx(nx),
		.ny(ny)
	) router_i (
		.clk(clk),
		.reset(reset),
		.current_x(my_x),
		.current_y(my_y),
		.flit_in(flit_in),
		.flit_in_we(flit_in_we),
		.credit_out(credit_out),
		.flit_out(flit_out),
		.flit_out_we(flit_out_we),
		.credit_in(credit_in)
	);

	task automatic check_flit(input string name, input flit_t exp, input flit_t act);
		if (exp.head !== act.head || exp.tail !== act.tail || exp.payload !== act.payload) begin
			$display("ERR %s flit expected head %b tail %b payload %h, actual head %b tail %b payload %h",
				name, exp.head, exp.tail, exp.payload, act.head, act.tail, act.payload);
			err_flit++;
		end
	endtask

	task automatic check_port(input string name, input port_mask_t exp, input port_mask_t act);
		if (exp !== act) begin
			$display("ERR %s port expected %b actual %b", name, exp, act);
			err_port++;
		end
	endtask

	task automatic check_credit(input string name, input vc_mask_t exp, input vc_mask_t act);
		if (exp !== act) begin
			$display("ERR %s credit expected %b actual %b", name, exp, act);
			err_credit++;
		end
	endtask

	task automatic check_latency(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("ERR %s latency expected %0d actual %0d", name, exp, act);
			err_lat++;
		end
	endtask

	// columns: name, in port, channel, length, dest x, dest y, payload seed, out port
	task automatic load_stim(output logic ok);
		int fd;
		string line;
		string nm;
		int ip;
		int vc;
		int len;
		int dx;
		int dy;
		int ep;
		int n;
		logic [31:0] ps;
		logic [31:0] r;
		flit_t f;
		ok = 1'b0;
		fd = $fopen("router_stim.txt", "r");
		if (fd == 0)
			return;
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line, "%s %d %d %d %d %d %h %d", nm, ip, vc, len, dx, dy, ps, ep);
			if (n != 8)
				continue;
			names.push_back(nm);
			in_port.push_back(ip);
			in_vc.push_back(vc);
			pkt_len.push_back(len);
			exp_port.push_back(ep);
			first_flit.push_back(stim_flits.size());
			for (int k = 0; k < len; k++) begin
				r = $random(seed);
				f.head = (k == 0);
				f.tail = (k == len - 1);
				f.vc_mask = vc_mask_t'(1 << vc);
				if (k == 0) // route fields in the low bits of a head
					f.payload = {r[payload_w-1:2*coord_w] ^ ps[payload_w-1:2*coord_w],
						coord_t'(dy), coord_t'(dx)};
				else
					f.payload = r ^ ps;
				stim_flits.push_back(f);
			end
		end
		$fclose(fd);
		for (int i = 0; i < names.size(); i++) begin
			lone.push_back(pkt_len[i] == 1 &&
				(i == 0 || names[i-1] != names[i]) &&
				(i == names.size() - 1 || names[i+1] != names[i]));
		end
		ok = (names.size() > 0);
	endtask

	task automatic send_packet(input int idx);
		int p;
		int v;
		exp_t e;
		p = in_port[idx];
		v = in_vc[idx];
		for (int k = 0; k < pkt_len[idx]; k++) begin
			@(posedge clk);
			while (up_credit[p][v] == 0) begin // no credit, hold the flit back
				flit_in_we[p] <= 1'b0;
				@(posedge clk);
			end
			e.f = stim_flits[first_flit[idx] + k];
			e.pkt = 16'(idx);
			e.wr_cycle = 32'(cycle + 1);
			exp_q[exp_port[idx]].push_back(e);
			flit_in[p] <= e.f;
			flit_in_we[p] <= 1'b1;
			up_credit[p][v]--;
			sent_cnt[p][v]++;
		end
		@(posedge clk);
		flit_in_we[p] <= 1'b0;
	endtask

	task automatic take_flit(input int o, input flit_t f);
		int v;
		int src;
		int hit;
		exp_t e;
		if (!$onehot(f.vc_mask)) begin
			$display("port %0d sent a flit whose vc_mask %b is not one-hot", o, f.vc_mask);
			err_other++;
			return;
		end
		v = 0;
		for (int k = 0; k < num_vc; k++)
			if (f.vc_mask[k])
				v = k;
		owed[o][v]++;
		if (owed[o][v] > b) begin
			$display("port %0d channel %0d sent more than %0d flits without credit", o, v, b);
			err_other++;
		end
		if (hold_east && o == port_east)
			east_held++;
		src = -1;
		hit = -1;
		if (f.head) begin
			if (open_pkt[o][v]) begin
				$display("port %0d channel %0d started a packet before the last tail", o, v);
				err_other++;
			end
			for (int q = 0; q < num_ports; q++)
				for (int k = 0; k < exp_q[q].size(); k++)
					if (hit < 0 && exp_q[q][k].f.head && exp_q[q][k].f.payload == f.payload) begin
						src = q;
						hit = k;
					end
			if (hit < 0) begin
				$display("port %0d sent a head flit %h that no packet expects", o, f.payload);
				err_other++;
				return;
			end
			e = exp_q[src][hit];
			check_port(names[e.pkt], port_mask_t'(1 << src), port_mask_t'(1 << o));
			cur_pkt[o][v] = int'(e.pkt);
			cur_src[o][v] = src;
			open_pkt[o][v] = 1'b1;
			if (lone[e.pkt])
				check_latency(names[e.pkt], 3, cycle - int'(e.wr_cycle));
		end else begin
			if (!open_pkt[o][v]) begin
				$display("port %0d channel %0d sent a body flit outside a packet", o, v);
				err_other++;
				return;
			end
			src = cur_src[o][v];
			for (int k = 0; k < exp_q[src].size(); k++)
				if (hit < 0 && int'(exp_q[src][k].pkt) == cur_pkt[o][v])
					hit = k;
			if (hit < 0) begin
				$display("port %0d channel %0d sent more flits than its packet holds", o, v);
				err_other++;
				return;
			end
		end
		e = exp_q[src][hit];
		exp_q[src].delete(hit);
		check_flit(names[e.pkt], e.f, f);
		if (f.tail)
			open_pkt[o][v] = 1'b0;
	endtask

	function automatic logic quiet();
		for (int p = 0; p < num_ports; p++) begin
			if (exp_q[p].size() != 0)
				return 1'b0;
			for (int v = 0; v < num_vc; v++)
				if (owed[p][v] != 0 || up_credit[p][v] != b || open_pkt[p][v])
					return 1'b0;
		end
		return 1'b1;
	endfunction

	// lines with the same name are sent together
	task automatic run_group(input int first, input int last);
		int east_total;
		int target;
		logic hold;
		hold = (names[first] == "east_hold");
		east_total = 0;
		for (int i = first; i <= last; i++)
			if (exp_port[i] == port_east)
				east_total += pkt_len[i];
		target = (east_total < num_vc * b) ? east_total : num_vc * b;
		east_held = 0;
		hold_east <= hold;
		for (int i = first; i <= last; i++) begin
			int n;
			n = i;
			fork
				send_packet(n);
			join_none
		end
		wait fork;
		if (hold) begin
			while (east_held < target)
				@(posedge clk);
			hold_east <= 1'b0; // hand the withheld credits back
		end
		do
			@(posedge clk);
		while (!quiet());
	endtask

	always @(negedge clk) begin
		port_mask_t we_mask;
		cycle++;
		if (!reset) begin
			for (int p = 0; p < num_ports; p++) begin
				we_mask[p] = flit_out_we[p];
				if (flit_in_we[p])
					first_write = 1'b1;
			end
			if (!first_write) begin // nothing may move before the first write
				check_port("reset_idle", '0, we_mask);
				for (int p = 0; p < num_ports; p++)
					check_credit("reset_idle", '0, credit_out[p]);
			end
			for (int p = 0; p < num_ports; p++) begin
				for (int v = 0; v < num_vc; v++) begin
					if (credit_out[p][v]) begin
						credit_cnt[p][v]++;
						up_credit[p][v]++;
						if (up_credit[p][v] > b) begin
							$display("credit_out on port %0d channel %0d with no flit outstanding",
								p, v);
							err_credit++;
						end
					end
				end
			end
			for (int o = 0; o < num_ports; o++)
				if (flit_out_we[o])
					take_flit(o, flit_out[o]);
		end
	end

	// one credit per cycle and channel back to the DUT
	always @(posedge clk) begin
		for (int o = 0; o < num_ports; o++) begin
			for (int v = 0; v < num_vc; v++) begin
				if (owed[o][v] > 0 && !(hold_east && o == port_east)) begin
					credit_in[o][v] <= 1'b1;
					owed[o][v]--;
				end else begin
					credit_in[o][v] <= 1'b0;
				end
			end
		end
	end

	always @(posedge clk) begin
		if (cycle > limit) begin
			$display("timeout: the run did not end within %0d cycles", limit);
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		logic ok;
		int idx;
		int last;
		int total;
		vc_mask_t match;
		seed = 94;
		cycle = 0;
		limit = 200;
		hold_east = 1'b0;
		first_write = 1'b0;
		east_held = 0;
		err_flit = 0;
		err_port = 0;
		err_credit = 0;
		err_lat = 0;
		err_other = 0;
		for (int p = 0; p < num_ports; p++) begin
			flit_in[p] = '0;
			flit_in_we[p] = 1'b0;
			credit_in[p] = '0;
			for (int v = 0; v < num_vc; v++) begin
				up_credit[p][v] = b;
				owed[p][v] = 0;
				credit_cnt[p][v] = 0;
				sent_cnt[p][v] = 0;
				cur_pkt[p][v] = 0;
				cur_src[p][v] = 0;
				open_pkt[p][v] = 1'b0;
			end
		end
		load_stim(ok);
		if (!ok) begin
			$display("could not read any packet from router_stim.txt");
			$display("Finished with errors");
			$finish;
		end else begin
			limit = 20 * stim_flits.size() + 200;
			wait (reset === 1'b1);
			wait (reset === 1'b0);
			repeat (5) @(posedge clk); // idle stretch, outputs must stay low
			idx = 0;
			while (idx < names.size()) begin
				last = idx;
				while (last + 1 < names.size() && names[last+1] == names[idx])
					last++;
				run_group(idx, last);
				idx = last + 1;
			end
			for (int p = 0; p < num_ports; p++) begin
				for (int v = 0; v < num_vc; v++)
					match[v] = (credit_cnt[p][v] == sent_cnt[p][v]);
				check_credit("credit_count", '1, match);
			end
			total = err_flit + err_port + err_credit + err_lat + err_other;
			$display("errors: flit %0d, port %0d, credit %0d, latency %0d, other %0d, total %0d",
				err_flit, err_port, err_credit, err_lat, err_other, total);
			if (total == 0)
				$display("Finished with no errors");
			else
				$display("Finished with errors");
			$finish;
		end
	end

endmodule

//--- tb_clk_gen.sv
module tb_clk_gen (
	output logic clk,
	output logic reset
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

//--- vc_fifo.sv
module vc_fifo import noc_pkg::*; #(
	parameter int depth = 4
) (
	input logic clk,
	input logic reset,
	input logic wr,
	input flit_t din,
	input logic rd,
	output flit_t dout,
	output logic empty,
	output logic full
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	typedef logic [ptr_w-1:0] ptr_t;
	typedef logic [cnt_w-1:0] cnt_t;

	flit_t mem [depth];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	cnt_t count;

	function automatic ptr_t next_ptr(input ptr_t p);
		return (p == ptr_t'(depth - 1)) ? '0 : p + 1'b1; // wrap for any depth
	endfunction

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr)
				wr_ptr <= next_ptr(wr_ptr);
			if (rd)
				rd_ptr <= next_ptr(rd_ptr);
			if (wr && !rd)
				count <= count + 1'b1;
			else if (rd && !wr)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr)
			mem[wr_ptr] <= din;
	end

	assign dout = mem[rd_ptr]; // head of the buffer, valid when not empty
	assign empty = (count == '0);
	assign full = (count == cnt_t'(depth));

	// upstream credits must keep the buffer from overflowing
	assert property (@(posedge clk) disable iff (reset) !(wr && full));
	assert property (@(posedge clk) disable iff (reset) !(rd && empty));

endmodule

//--- vc_sw_alloc.sv
module vc_sw_alloc import noc_pkg::*; (
	input logic clk,
	input logic reset,
	input vc_mask_t req [num_ports],
	input port_mask_t dest_port [num_ports][num_vc],
	input vc_mask_t has_ovc [num_ports],
	input vc_mask_t held_ovc [num_ports][num_vc],
	input vc_mask_t ovc_free [num_ports],
	input vc_mask_t ovc_credit [num_ports],
	output vc_mask_t ovc_grant [num_ports][num_vc],
	output vc_mask_t sw_grant [num_ports],
	output port_mask_t grant_rows [num_ports],
	output vc_mask_t ovc_alloc [num_ports],
	output vc_mask_t flit_sent [num_ports],
	output vc_mask_t tail_sent [num_ports]
);

	localparam int max_w = num_ports * num_vc; // all input channels of the router
	localparam int ptr_w = $clog2(max_w);

	typedef logic [max_w-1:0] ch_vec_t;
	typedef logic [ptr_w-1:0] ptr_t;

	vc_mask_t eligible [num_ports];
	vc_mask_t vc_win [num_ports]; // first stage winner per input
	port_mask_t win_port [num_ports];
	vc_mask_t win_ovc [num_ports];
	port_mask_t grant_cols [num_ports];
	ch_vec_t ovc_pick [num_ports];
	ptr_t vc_ptr [num_ports];
	ptr_t in_ptr [num_ports];
	ptr_t ovc_ptr [num_ports];
	vc_mask_t sent_vc_q [num_ports];
	vc_mask_t sent_ovc_q [num_ports];
	port_mask_t sent_out_q [num_ports];

	// round robin over the low w bits starting at ptr
	function automatic ch_vec_t rr_pick(input ch_vec_t r, input int ptr, input int w);
		ch_vec_t g;
		int idx;
		logic found;
		g = '0;
		found = 1'b0;
		for (int k = 0; k < max_w; k++) begin
			idx = (ptr + k) % w;
			if (k < w && !found && r[idx]) begin
				g[idx] = 1'b1;
				found = 1'b1;
			end
		end
		return g;
	endfunction

	function automatic int first_idx(input ch_vec_t m);
		int idx;
		idx = 0;
		for (int k = max_w - 1; k >= 0; k--) begin
			if (m[k])
				idx = k;
		end
		return idx;
	endfunction

	// switch allocation in an input stage then an output stage
	always_comb begin
		logic credit_ok;
		port_mask_t out_req;
		logic granted;
		for (int i = 0; i < num_ports; i++) begin
			for (int v = 0; v < num_vc; v++) begin
				credit_ok = 1'b0;
				for (int o = 0; o < num_ports; o++) begin
					if (dest_port[i][v][o] && |(ovc_credit[o] & held_ovc[i][v]))
						credit_ok = 1'b1;
				end
				eligible[i][v] = req[i][v] & has_ovc[i][v] & credit_ok;
			end
			vc_win[i] = vc_mask_t'(rr_pick(ch_vec_t'(eligible[i]), int'(vc_ptr[i]), num_vc));
			win_port[i] = '0;
			win_ovc[i] = '0;
			for (int v = 0; v < num_vc; v++) begin
				if (vc_win[i][v]) begin
					win_port[i] = dest_port[i][v];
					win_ovc[i] = held_ovc[i][v];
				end
			end
		end
		for (int o = 0; o < num_ports; o++) begin
			for (int i = 0; i < num_ports; i++)
				out_req[i] = win_port[i][o];
			grant_rows[o] = port_mask_t'(rr_pick(ch_vec_t'(out_req), int'(in_ptr[o]), num_ports));
			flit_sent[o] = '0;
			for (int i = 0; i < num_ports; i++) begin
				if (grant_rows[o][i])
					flit_sent[o] = flit_sent[o] | win_ovc[i];
			end
		end
		for (int i = 0; i < num_ports; i++) begin
			granted = 1'b0;
			for (int o = 0; o < num_ports; o++) begin
				grant_cols[i][o] = grant_rows[o][i];
				granted = granted | grant_rows[o][i];
			end
			sw_grant[i] = granted ? vc_win[i] : '0;
		end
	end

	// output channel allocation, one channel per output per cycle
	always_comb begin
		ch_vec_t ovc_req;
		vc_mask_t free_pick;
		for (int o = 0; o < num_ports; o++) begin
			for (int i = 0; i < num_ports; i++) begin
				for (int v = 0; v < num_vc; v++)
					ovc_req[i*num_vc+v] = req[i][v] & ~has_ovc[i][v] & dest_port[i][v][o];
			end
			free_pick = ovc_free[o] & (~ovc_free[o] + 1'b1); // lowest free channel
			ovc_pick[o] = (|free_pick) ? rr_pick(ovc_req, int'(ovc_ptr[o]), max_w) : '0;
			ovc_alloc[o] = (|ovc_pick[o]) ? free_pick : '0;
		end
		for (int i = 0; i < num_ports; i++) begin
			for (int v = 0; v < num_vc; v++) begin
				ovc_grant[i][v] = '0;
				for (int o = 0; o < num_ports; o++) begin
					if (ovc_pick[o][i*num_vc+v])
						ovc_grant[i][v] = ovc_alloc[o];
				end
			end
		end
	end

	// a channel sent last cycle that lost its output channel sent a tail
	always_comb begin
		for (int o = 0; o < num_ports; o++) begin
			tail_sent[o] = '0;
			for (int i = 0; i < num_ports; i++) begin
				if (sent_out_q[i][o] && |(sent_vc_q[i] & ~has_ovc[i]))
					tail_sent[o] = tail_sent[o] | sent_ovc_q[i];
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int p = 0; p < num_ports; p++) begin
				vc_ptr[p] <= '0;
				in_ptr[p] <= '0;
				ovc_ptr[p] <= '0;
				sent_vc_q[p] <= '0;
				sent_ovc_q[p] <= '0;
				sent_out_q[p] <= '0;
			end
		end else begin
			for (int p = 0; p < num_ports; p++) begin
				if (|sw_grant[p])
					vc_ptr[p] <= ptr_t'((first_idx(ch_vec_t'(sw_grant[p])) + 1) % num_vc);
				if (|grant_rows[p])
					in_ptr[p] <= ptr_t'((first_idx(ch_vec_t'(grant_rows[p])) + 1) % num_ports);
				if (|ovc_pick[p])
					ovc_ptr[p] <= ptr_t'((first_idx(ovc_pick[p]) + 1) % max_w);
				sent_vc_q[p] <= sw_grant[p];
				sent_ovc_q[p] <= win_ovc[p];
				sent_out_q[p] <= grant_cols[p];
			end
		end
	end

	for (genvar p = 0; p < num_ports; p++) begin : g_chk
		// one input per output and one output per input
		assert property (@(posedge clk) disable iff (reset) $onehot0(grant_rows[p]));
		assert property (@(posedge clk) disable iff (reset) $onehot0(grant_cols[p]));
	end

endmodule
